// File: hw/simple_pkg.sv
package simple_pkg;

   localparam int word_w = 16;
   localparam int reg_n  = 8;
   localparam int reg_aw = $clog2(reg_n);
   localparam int pend_w = 3;    // Scoreboard counter width

   localparam logic [1:0] OP_LD  = 2'd0;
   localparam logic [1:0] OP_ST  = 2'd1;
   localparam logic [1:0] OP_IMM = 2'd2;
   localparam logic [1:0] OP_ALU = 2'd3;

   localparam logic [3:0] ALU_ADD = 4'd0;
   localparam logic [3:0] ALU_SUB = 4'd1;
   localparam logic [3:0] ALU_AND = 4'd2;
   localparam logic [3:0] ALU_OR  = 4'd3;
   localparam logic [3:0] ALU_XOR = 4'd4;
   localparam logic [3:0] ALU_CMP = 4'd5;
   localparam logic [3:0] ALU_MOV = 4'd6;
   localparam logic [3:0] ALU_SLL = 4'd8;
   localparam logic [3:0] ALU_SLR = 4'd9;     // Rotate left
   localparam logic [3:0] ALU_SRL = 4'd10;
   localparam logic [3:0] ALU_SRA = 4'd11;
   localparam logic [3:0] ALU_IN  = 4'd12;
   localparam logic [3:0] ALU_OUT = 4'd13;
   localparam logic [3:0] ALU_HLT = 4'd15;
   localparam logic [3:0] ALU_ADR = 4'd15;    // Shares the halt code

   localparam logic [1:0] SRCA_REG  = 2'd0;   // rb
   localparam logic [1:0] SRCA_PC   = 2'd1;
   localparam logic [1:0] SRCA_ZERO = 2'd2;

   localparam logic [1:0] SRCB_REG   = 2'd0;  // ra
   localparam logic [1:0] SRCB_SHAMT = 2'd1;
   localparam logic [1:0] SRCB_IMM   = 2'd2;
   localparam logic [1:0] SRCB_IN    = 2'd3;

   localparam logic [1:0] WD_ALU  = 2'd0;
   localparam logic [1:0] WD_MEM  = 2'd1;
   localparam logic [1:0] WD_LINK = 2'd2;
   localparam logic [1:0] WD_IMM  = 2'd3;

   localparam logic [2:0] JMP_NONE   = 3'd0;
   localparam logic [2:0] JMP_ALWAYS = 3'd1;
   localparam logic [2:0] JMP_BE     = 3'd2;
   localparam logic [2:0] JMP_BLT    = 3'd3;
   localparam logic [2:0] JMP_BLE    = 3'd4;
   localparam logic [2:0] JMP_BNE    = 3'd5;

endpackage

// File: hw/ctrl_if.sv
interface ctrl_if;

   logic                            is_halt, mem_write, from_mem;
   logic                            regwrite, regwrite_adr, out_en;
   logic [1:0]                      src_a, src_b;
   logic [3:0]                      alu_op;
   logic [1:0]                      wd_sel;
   logic [2:0]                      jump;
   logic [simple_pkg::reg_aw-1:0]   ra, rb;
   logic [simple_pkg::word_w-1:0]   imm, pc;
   logic [simple_pkg::word_w-1:0]   ra_val, rb_val;
   logic                            valid;

   modport dec (output is_halt, mem_write, from_mem, regwrite, regwrite_adr, out_en,
                output src_a, src_b, alu_op, wd_sel, jump, ra, rb);

   modport rd (input ra, rb, output ra_val, rb_val);

   modport ex (input is_halt, mem_write, from_mem, regwrite, regwrite_adr, out_en,
               input src_a, src_b, alu_op, wd_sel, jump, ra, rb,
               input imm, pc, ra_val, rb_val, valid);

endinterface

// File: hw/controller.sv
module controller (
   input  logic                           flushed,
   input  logic [simple_pkg::word_w-1:0]  inst_id,
   ctrl_if.dec                            dec,
   output logic                           use_ra,
   output logic                           use_rb
);

   logic [1:0] op;
   logic [3:0] ty;

   assign op     = inst_id[15:14];
   assign dec.ra = inst_id[13:11];
   assign dec.rb = inst_id[10:8];
   assign ty     = inst_id[7:4];

   always_comb begin
      dec.jump         = simple_pkg::JMP_NONE;
      dec.is_halt      = 1'b0;
      dec.mem_write    = 1'b0;
      dec.from_mem     = 1'b0;
      dec.regwrite     = 1'b0;
      dec.regwrite_adr = 1'b0;     // Destination rb unless set
      dec.out_en       = 1'b0;
      dec.src_a        = simple_pkg::SRCA_REG;
      dec.src_b        = simple_pkg::SRCB_REG;
      dec.alu_op       = simple_pkg::ALU_ADR;
      dec.wd_sel       = simple_pkg::WD_ALU;
      use_ra           = 1'b0;
      use_rb           = 1'b0;

      if (!flushed) begin
         case (op)
            simple_pkg::OP_LD: begin
               use_rb           = 1'b1;
               dec.regwrite     = 1'b1;
               dec.regwrite_adr = 1'b1;
               dec.from_mem     = 1'b1;
               dec.src_b        = simple_pkg::SRCB_IMM;
            end
            simple_pkg::OP_ST: begin
               use_ra        = 1'b1;
               use_rb        = 1'b1;
               dec.mem_write = 1'b1;
               dec.src_b     = simple_pkg::SRCB_IMM;
            end
            simple_pkg::OP_IMM: begin
               dec.src_b = simple_pkg::SRCB_IMM;
               case (dec.ra)
                  3'd0: begin                  // LI
                     dec.regwrite = 1'b1;
                     dec.wd_sel   = simple_pkg::WD_IMM;
                  end
                  3'd1: begin                  // ADDI
                     use_rb       = 1'b1;
                     dec.regwrite = 1'b1;
                     dec.alu_op   = simple_pkg::ALU_ADD;
                  end
                  3'd2: begin                  // CMPI
                     use_rb     = 1'b1;
                     dec.alu_op = simple_pkg::ALU_CMP;
                  end
                  3'd4: begin                  // B
                     dec.jump  = simple_pkg::JMP_ALWAYS;
                     dec.src_a = simple_pkg::SRCA_PC;
                  end
                  3'd5: begin                  // BAL, link into rb
                     dec.jump     = simple_pkg::JMP_ALWAYS;
                     dec.src_a    = simple_pkg::SRCA_PC;
                     dec.regwrite = 1'b1;
                     dec.wd_sel   = simple_pkg::WD_LINK;
                  end
                  3'd6: begin                  // BR
                     use_rb   = 1'b1;
                     dec.jump = simple_pkg::JMP_ALWAYS;
                  end
                  3'd7: begin
                     dec.src_a = simple_pkg::SRCA_PC;
                     case (dec.rb)
                        3'd0:    dec.jump = simple_pkg::JMP_BE;
                        3'd1:    dec.jump = simple_pkg::JMP_BLT;
                        3'd2:    dec.jump = simple_pkg::JMP_BLE;
                        3'd3:    dec.jump = simple_pkg::JMP_BNE;
                        default: dec.jump = simple_pkg::JMP_ALWAYS;
                     endcase
                  end
                  default: ;
               endcase
            end
            simple_pkg::OP_ALU: begin
               dec.alu_op = ty;
               case (ty)
                  simple_pkg::ALU_ADD, simple_pkg::ALU_SUB, simple_pkg::ALU_AND,
                  simple_pkg::ALU_OR, simple_pkg::ALU_XOR: begin
                     use_ra       = 1'b1;
                     use_rb       = 1'b1;
                     dec.regwrite = 1'b1;
                  end
                  simple_pkg::ALU_CMP: begin
                     use_ra = 1'b1;
                     use_rb = 1'b1;
                  end
                  simple_pkg::ALU_MOV: begin
                     use_ra       = 1'b1;
                     dec.regwrite = 1'b1;
                     dec.src_a    = simple_pkg::SRCA_ZERO;
                  end
                  simple_pkg::ALU_SLL, simple_pkg::ALU_SLR,
                  simple_pkg::ALU_SRL, simple_pkg::ALU_SRA: begin
                     use_rb       = 1'b1;
                     dec.regwrite = 1'b1;
                     dec.src_b    = simple_pkg::SRCB_SHAMT;
                  end
                  simple_pkg::ALU_IN: begin
                     dec.regwrite = 1'b1;
                     dec.src_a    = simple_pkg::SRCA_ZERO;
                     dec.src_b    = simple_pkg::SRCB_IN;
                  end
                  simple_pkg::ALU_OUT: begin
                     use_ra     = 1'b1;
                     dec.out_en = 1'b1;
                  end
                  simple_pkg::ALU_HLT: dec.is_halt = 1'b1;
                  default: ;
               endcase
            end
         endcase
      end
   end

endmodule

// File: hw/hazard_unit.sv
module hazard_unit (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          use_ra,
   input  logic                          use_rb,
   input  logic [simple_pkg::reg_aw-1:0] ra,
   input  logic [simple_pkg::reg_aw-1:0] rb,
   input  logic                          issue,
   input  logic [simple_pkg::reg_aw-1:0] issue_dst,
   input  logic                          wb_en,
   input  logic [simple_pkg::reg_aw-1:0] wb_dst,
   output logic                          stall
);

   logic [simple_pkg::pend_w-1:0] pend [simple_pkg::reg_n];
   logic [simple_pkg::reg_n-1:0]  inc_v, dec_v;

   always_comb begin
      inc_v            = '0;
      dec_v            = '0;
      inc_v[issue_dst] = issue;
      dec_v[wb_dst]    = wb_en;
   end

   // Issue and write-back on the same register cancel out
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < simple_pkg::reg_n; i++) begin
            pend[i] <= '0;
         end
      end else begin
         for (int i = 0; i < simple_pkg::reg_n; i++) begin
            if (inc_v[i] && !dec_v[i]) begin
               pend[i] <= pend[i] + 1'b1;
            end else if (dec_v[i] && !inc_v[i]) begin
               pend[i] <= pend[i] - 1'b1;
            end
         end
      end
   end

   assign stall = (use_ra && pend[ra] != '0) || (use_rb && pend[rb] != '0);

endmodule

// File: hw/reg_file.sv
module reg_file (
   input  logic                          clk,
   input  logic                          rst_n,
   ctrl_if.rd                            rd,
   input  logic                          we,
   input  logic [simple_pkg::reg_aw-1:0] wa,
   input  logic [simple_pkg::word_w-1:0] wd
);

   logic [simple_pkg::word_w-1:0] regs [simple_pkg::reg_n];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < simple_pkg::reg_n; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wa] <= wd;
      end
   end

   assign rd.ra_val = regs[rd.ra];   // Combinational read ports
   assign rd.rb_val = regs[rd.rb];

endmodule

// File: hw/alu.sv
module alu (
   input  logic [3:0]                    op,
   input  logic [simple_pkg::word_w-1:0] a,
   input  logic [simple_pkg::word_w-1:0] b,
   output logic [simple_pkg::word_w-1:0] y,
   output logic                          s,
   output logic                          z,
   output logic                          c,
   output logic                          v,
   output logic                          flag_we
);

   logic [simple_pkg::word_w:0] sum;
   logic [3:0]                  sh;

   assign sh = b[3:0];

   always_comb begin
      sum = '0;
      y   = '0;
      c   = 1'b0;
      v   = 1'b0;
      case (op)
         simple_pkg::ALU_ADD, simple_pkg::ALU_ADR: begin
            sum = {1'b0, a} + {1'b0, b};
            y   = sum[simple_pkg::word_w-1:0];
            c   = sum[simple_pkg::word_w];
            v   = ~(a[15] ^ b[15]) & (a[15] ^ y[15]);
         end
         simple_pkg::ALU_SUB, simple_pkg::ALU_CMP: begin
            sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
            y   = sum[simple_pkg::word_w-1:0];
            c   = sum[simple_pkg::word_w];      // Carry means no borrow
            v   = (a[15] ^ b[15]) & (a[15] ^ y[15]);
         end
         simple_pkg::ALU_AND: y = a & b;
         simple_pkg::ALU_OR:  y = a | b;
         simple_pkg::ALU_XOR: y = a ^ b;
         simple_pkg::ALU_MOV, simple_pkg::ALU_IN: y = b;
         simple_pkg::ALU_SLL: {c, y} = {1'b0, a} << sh;    // Last bit out in c
         simple_pkg::ALU_SLR: y = (a << sh) | (a >> (5'd16 - sh));
         simple_pkg::ALU_SRL: {y, c} = {a, 1'b0} >> sh;
         simple_pkg::ALU_SRA: {y, c} = $signed({a, 1'b0}) >>> sh;
         default: ;
      endcase
   end

   assign s = y[simple_pkg::word_w-1];
   assign z = (y == '0);

   always_comb begin
      flag_we = (op <= simple_pkg::ALU_CMP) ||
                (op >= simple_pkg::ALU_SLL && op <= simple_pkg::ALU_SRA);
   end

endmodule

// File: hw/branch_unit.sv
module branch_unit (
   input  logic [2:0] jump,
   input  logic       s,
   input  logic       z,
   input  logic       v,
   output logic       taken
);

   always_comb begin
      case (jump)
         simple_pkg::JMP_ALWAYS: taken = 1'b1;
         simple_pkg::JMP_BE:     taken = z;
         simple_pkg::JMP_BLT:    taken = s ^ v;     // Signed less than
         simple_pkg::JMP_BLE:    taken = z | (s ^ v);
         simple_pkg::JMP_BNE:    taken = ~z;
         default:                taken = 1'b0;      // JMP_NONE
      endcase
   end

endmodule

// File: hw/ex_stage.sv
module ex_stage (
   input  logic                          clk,
   input  logic                          rst_n,
   ctrl_if.ex                            ex,
   input  logic [simple_pkg::word_w-1:0] in_data,
   output logic [simple_pkg::word_w-1:0] dmem_addr,
   output logic [simple_pkg::word_w-1:0] dmem_wdata,
   output logic                          dmem_we,
   input  logic [simple_pkg::word_w-1:0] dmem_rdata,
   output logic [simple_pkg::word_w-1:0] out_data,
   output logic                          out_valid,
   output logic                          wb_en,
   output logic [simple_pkg::reg_aw-1:0] wb_dst,
   output logic [simple_pkg::word_w-1:0] wb_data,
   output logic                          taken,
   output logic [simple_pkg::word_w-1:0] target,
   output logic                          halt
);

   logic                          valid_q, is_halt_q, mem_write_q, from_mem_q;
   logic                          regwrite_q, regwrite_adr_q, out_en_q;
   logic [1:0]                    src_a_q, src_b_q, wd_sel_q, wd_sel_e;
   logic [3:0]                    alu_op_q;
   logic [2:0]                    jump_q;
   logic [simple_pkg::reg_aw-1:0] ra_q, rb_q;
   logic [simple_pkg::word_w-1:0] imm_q, pc_q, ra_val_q, rb_val_q;
   logic [simple_pkg::word_w-1:0] op_a, op_b, alu_y;
   logic                          a_s, a_z, a_v, flag_we, br_taken;
   logic [2:0]                    flags_q;   // s z v

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         flags_q <= '0;
      end else begin
         valid_q <= ex.valid;
         if (valid_q && flag_we) begin
            flags_q <= {a_s, a_z, a_v};
         end
      end
   end

   always_ff @(posedge clk) begin
      is_halt_q      <= ex.is_halt;
      mem_write_q    <= ex.mem_write;
      from_mem_q     <= ex.from_mem;
      regwrite_q     <= ex.regwrite;
      regwrite_adr_q <= ex.regwrite_adr;
      out_en_q       <= ex.out_en;
      src_a_q        <= ex.src_a;
      src_b_q        <= ex.src_b;
      alu_op_q       <= ex.alu_op;
      wd_sel_q       <= ex.wd_sel;
      jump_q         <= ex.jump;
      ra_q           <= ex.ra;
      rb_q           <= ex.rb;
      imm_q          <= ex.imm;
      pc_q           <= ex.pc;
      ra_val_q       <= ex.ra_val;
      rb_val_q       <= ex.rb_val;
   end

   always_comb begin
      case (src_a_q)
         simple_pkg::SRCA_REG: op_a = rb_val_q;
         simple_pkg::SRCA_PC:  op_a = pc_q;
         default:              op_a = '0;
      endcase
      op_b = imm_q;
      case (src_b_q)
         simple_pkg::SRCB_REG:   op_b = ra_val_q;
         simple_pkg::SRCB_SHAMT: op_b = {{(simple_pkg::word_w-4){1'b0}}, imm_q[3:0]};
         simple_pkg::SRCB_IMM:   op_b = imm_q;
         simple_pkg::SRCB_IN:    op_b = in_data;
      endcase
   end

   alu u_alu (
      .op      (alu_op_q),
      .a       (op_a),
      .b       (op_b),
      .y       (alu_y),
      .s       (a_s),
      .z       (a_z),
      .c       (),
      .v       (a_v),
      .flag_we (flag_we)
   );

   branch_unit u_branch (
      .jump  (jump_q),
      .s     (flags_q[2]),
      .z     (flags_q[1]),
      .v     (flags_q[0]),
      .taken (br_taken)
   );

   assign wd_sel_e = from_mem_q ? simple_pkg::WD_MEM : wd_sel_q;

   always_comb begin
      case (wd_sel_e)
         simple_pkg::WD_MEM:  wb_data = dmem_rdata;
         simple_pkg::WD_LINK: wb_data = pc_q + 1'b1;
         simple_pkg::WD_IMM:  wb_data = imm_q;
         default:             wb_data = alu_y;
      endcase
   end

   assign dmem_addr  = alu_y;
   assign dmem_wdata = ra_val_q;
   assign dmem_we    = valid_q & mem_write_q;
   assign out_data   = ra_val_q;
   assign out_valid  = valid_q & out_en_q;
   assign wb_en      = valid_q & regwrite_q;
   assign wb_dst     = regwrite_adr_q ? ra_q : rb_q;
   assign taken      = valid_q & br_taken;
   assign target     = alu_y;                   // pc or rb plus offset
   assign halt       = valid_q & is_halt_q;

endmodule

// File: hw/simple_core.sv
module simple_core (
   input  logic                          clk,
   input  logic                          rst_n,
   output logic [simple_pkg::word_w-1:0] imem_addr,
   input  logic [simple_pkg::word_w-1:0] imem_data,
   output logic [simple_pkg::word_w-1:0] dmem_addr,
   output logic [simple_pkg::word_w-1:0] dmem_wdata,
   output logic                          dmem_we,
   input  logic [simple_pkg::word_w-1:0] dmem_rdata,
   input  logic [simple_pkg::word_w-1:0] in_data,
   output logic [simple_pkg::word_w-1:0] out_data,
   output logic                          out_valid,
   output logic                          halted
);

   logic [simple_pkg::word_w-1:0] pc, id_inst, id_pc, target, wb_data;
   logic                          id_valid, flushed, stall, use_ra, use_rb;
   logic                          taken, halt, wb_en, fetch;
   logic [simple_pkg::reg_aw-1:0] wb_dst;

   ctrl_if cif ();

   assign imem_addr = pc;
   assign flushed   = ~id_valid | taken | halt | halted;
   assign fetch     = ~(halt | halted | taken | stall);
   assign cif.pc    = id_pc;
   assign cif.imm   = {{(simple_pkg::word_w-8){id_inst[7]}}, id_inst[7:0]};
   assign cif.valid = ~flushed & ~stall;        // Bubble on stall or flush

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc       <= '0;
         id_valid <= 1'b0;
         halted   <= 1'b0;
      end else if (halt || halted) begin
         halted   <= 1'b1;                      // Fetch frozen for good
         id_valid <= 1'b0;
      end else if (taken) begin
         pc       <= target;
         id_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc + 1'b1;
         id_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch) begin
         id_inst <= imem_data;
         id_pc   <= pc;
      end
   end

   controller u_ctrl (
      .flushed (flushed),
      .inst_id (id_inst),
      .dec     (cif.dec),
      .use_ra  (use_ra),
      .use_rb  (use_rb)
   );

   hazard_unit u_hazard (
      .clk       (clk),
      .rst_n     (rst_n),
      .use_ra    (use_ra),
      .use_rb    (use_rb),
      .ra        (cif.ra),
      .rb        (cif.rb),
      .issue     (cif.valid & cif.regwrite),
      .issue_dst (cif.regwrite_adr ? cif.ra : cif.rb),
      .wb_en     (wb_en),
      .wb_dst    (wb_dst),
      .stall     (stall)
   );

   reg_file u_rf (
      .clk   (clk),
      .rst_n (rst_n),
      .rd    (cif.rd),
      .we    (wb_en),
      .wa    (wb_dst),
      .wd    (wb_data)
   );

   ex_stage u_ex (
      .clk        (clk),
      .rst_n      (rst_n),
      .ex         (cif.ex),
      .in_data    (in_data),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_rdata (dmem_rdata),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .wb_en      (wb_en),
      .wb_dst     (wb_dst),
      .wb_data    (wb_data),
      .taken      (taken),
      .target     (target),
      .halt       (halt)
   );

endmodule

// File: tests/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int prog_len = 61;

// Test ids: 0 arith, 1 load_store, 2 branches, 3 call_return, 4 dependent, 5 halt

function automatic logic [15:0] alu_inst(input logic [3:0] ty, input logic [2:0] ra,
                                         input logic [2:0] rb);
   return {2'b11, ra, rb, ty, 4'd0};
endfunction

function automatic logic [15:0] shift_inst(input logic [3:0] ty, input logic [2:0] rb,
                                           input logic [3:0] sh);
   return {2'b11, 3'd0, rb, ty, sh};
endfunction

function automatic logic [15:0] imm_inst(input logic [2:0] sub, input logic [2:0] rb,
                                         input logic [7:0] d);
   return {2'b10, sub, rb, d};
endfunction

function automatic logic [15:0] mem_inst(input logic [1:0] op, input logic [2:0] ra,
                                         input logic [2:0] rb, input logic [7:0] d);
   return {op, ra, rb, d};
endfunction

task automatic expect_out(input logic [15:0] val, input logic is_in, input int test);
   exp_val[exp_cnt]  = val;
   exp_in[exp_cnt]   = is_in;
   exp_test[exp_cnt] = test;
   exp_cnt++;
endtask

task automatic load_program();
   imem[0]  = imm_inst(3'd0, 3'd1, 8'd5);          // LI r1, 5
   imem[1]  = imm_inst(3'd0, 3'd2, 8'hFD);         // LI r2, -3
   imem[2]  = alu_inst(4'd13, 3'd1, 3'd0);
   imem[3]  = alu_inst(4'd13, 3'd2, 3'd0);
   imem[4]  = imm_inst(3'd1, 3'd1, 8'd10);         // ADDI r1 -> 15
   imem[5]  = alu_inst(4'd13, 3'd1, 3'd0);
   imem[6]  = imm_inst(3'd0, 3'd3, 8'd12);
   imem[7]  = alu_inst(4'd0, 3'd1, 3'd3);          // r3 = 12 + 15
   imem[8]  = alu_inst(4'd13, 3'd3, 3'd0);
   imem[9]  = alu_inst(4'd1, 3'd1, 3'd3);          // r3 = 27 - 15
   imem[10] = alu_inst(4'd13, 3'd3, 3'd0);
   imem[11] = alu_inst(4'd2, 3'd2, 3'd1);          // r1 = 0xF & 0xFFFD
   imem[12] = alu_inst(4'd13, 3'd1, 3'd0);
   imem[13] = imm_inst(3'd0, 3'd4, 8'h30);
   imem[14] = alu_inst(4'd3, 3'd4, 3'd1);
   imem[15] = alu_inst(4'd13, 3'd1, 3'd0);
   imem[16] = alu_inst(4'd4, 3'd2, 3'd1);
   imem[17] = alu_inst(4'd13, 3'd1, 3'd0);
   imem[18] = alu_inst(4'd6, 3'd1, 3'd5);          // MOV r5 = r1
   imem[19] = shift_inst(4'd8, 3'd5, 4'd4);
   imem[20] = alu_inst(4'd13, 3'd5, 3'd0);
   imem[21] = shift_inst(4'd9, 3'd5, 4'd4);        // Rotate
   imem[22] = alu_inst(4'd13, 3'd5, 3'd0);
   imem[23] = shift_inst(4'd10, 3'd5, 4'd8);
   imem[24] = alu_inst(4'd13, 3'd5, 3'd0);
   imem[25] = shift_inst(4'd11, 3'd1, 4'd4);
   imem[26] = alu_inst(4'd13, 3'd1, 3'd0);
   imem[27] = imm_inst(3'd0, 3'd6, 8'h40);
   imem[28] = mem_inst(2'd1, 3'd5, 3'd6, 8'hFE);   // ST r5 -> [62]
   imem[29] = mem_inst(2'd0, 3'd7, 3'd6, 8'hFE);
   imem[30] = alu_inst(4'd13, 3'd7, 3'd0);         // Load use
   imem[31] = mem_inst(2'd1, 3'd3, 3'd6, 8'd5);    // ST r3 -> [69]
   imem[32] = mem_inst(2'd0, 3'd7, 3'd6, 8'd5);
   imem[33] = alu_inst(4'd13, 3'd7, 3'd0);
   imem[34] = imm_inst(3'd2, 3'd3, 8'd12);         // CMPI equal
   imem[35] = imm_inst(3'd7, 3'd0, 8'd2);          // BE taken
   imem[36] = alu_inst(4'd13, 3'd4, 3'd0);
   imem[37] = alu_inst(4'd13, 3'd6, 3'd0);
   imem[38] = imm_inst(3'd7, 3'd3, 8'd2);          // BNE not taken
   imem[39] = alu_inst(4'd13, 3'd3, 3'd0);
   imem[40] = imm_inst(3'd2, 3'd3, 8'd20);         // CMPI less
   imem[41] = imm_inst(3'd7, 3'd1, 8'd2);
   imem[42] = alu_inst(4'd13, 3'd4, 3'd0);
   imem[43] = imm_inst(3'd7, 3'd2, 8'd2);
   imem[44] = alu_inst(4'd13, 3'd4, 3'd0);
   imem[45] = imm_inst(3'd7, 3'd0, 8'd2);          // BE not taken
   imem[46] = alu_inst(4'd13, 3'd6, 3'd0);
   imem[47] = imm_inst(3'd2, 3'd3, 8'd5);          // CMPI greater
   imem[48] = imm_inst(3'd7, 3'd1, 8'd2);
   imem[49] = imm_inst(3'd7, 3'd2, 8'd2);
   imem[50] = imm_inst(3'd7, 3'd3, 8'd2);
   imem[51] = alu_inst(4'd13, 3'd4, 3'd0);
   imem[52] = alu_inst(4'd13, 3'd3, 3'd0);
   imem[53] = imm_inst(3'd5, 3'd7, 8'd6);          // BAL r7 to 59
   imem[54] = alu_inst(4'd13, 3'd7, 3'd0);
   imem[55] = alu_inst(4'd12, 3'd0, 3'd2);         // IN r2
   imem[56] = alu_inst(4'd13, 3'd2, 3'd0);
   imem[57] = alu_inst(4'd15, 3'd0, 3'd0);
   imem[58] = alu_inst(4'd13, 3'd4, 3'd0);         // Never reached
   imem[59] = alu_inst(4'd13, 3'd1, 3'd0);
   imem[60] = imm_inst(3'd6, 3'd7, 8'd0);          // BR r7

   expect_out(16'h0005, 1'b0, 0);
   expect_out(16'hFFFD, 1'b0, 0);
   expect_out(16'h000F, 1'b0, 0);
   expect_out(16'h001B, 1'b0, 0);
   expect_out(16'h000C, 1'b0, 0);
   expect_out(16'h000D, 1'b0, 0);
   expect_out(16'h003D, 1'b0, 0);
   expect_out(16'hFFC0, 1'b0, 0);
   expect_out(16'hFC00, 1'b0, 0);
   expect_out(16'hC00F, 1'b0, 0);
   expect_out(16'h00C0, 1'b0, 0);
   expect_out(16'hFFFC, 1'b0, 0);
   expect_out(16'h00C0, 1'b0, 1);
   expect_out(16'h000C, 1'b0, 1);
   expect_out(16'h0040, 1'b0, 2);
   expect_out(16'h000C, 1'b0, 2);
   expect_out(16'h0040, 1'b0, 2);
   expect_out(16'h000C, 1'b0, 2);
   expect_out(16'hFFFC, 1'b0, 3);
   expect_out(16'h0036, 1'b0, 3);    // Link value 54
   expect_out(16'h0000, 1'b1, 4);    // Value taken from in_data

   chk_addr[0] = 8'd62;
   chk_val[0]  = 16'h00C0;
   chk_addr[1] = 8'd69;
   chk_val[1]  = 16'h000C;
endtask

`endif

// File: tests/tb_simple_core.sv
module tb_simple_core;

   logic        clk, rst_n;
   logic [15:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
   logic [15:0] in_data, out_data;
   logic        dmem_we, out_valid, halted;

   logic [15:0] imem [256];
   logic [15:0] dmem [256];
   logic [15:0] exp_val [32];
   logic        exp_in [32];
   int          exp_test [32];
   logic [7:0]  chk_addr [2];
   logic [15:0] chk_val [2];
   int          exp_cnt = 0;
   int          out_idx = 0;
   int          errors = 0;
   int          test_err [6];
   int          passed = 0;
   int          failed = 0;
   int          cycles = 0;
   logic [15:0] lfsr_q = 16'd24;
   logic [15:0] expv;
   int          cur_t;

   `include "tb_program.svh"

   localparam int cycle_limit = 3 * prog_len + 50;

   simple_core u_dut (.*);

   always #5 clk = ~clk;

   assign imem_data  = imem[imem_addr[7:0]];
   assign dmem_rdata = dmem[dmem_addr[7:0]];    // Combinational read

   always @(posedge clk) begin
      if (dmem_we) begin
         dmem[dmem_addr[7:0]] <= dmem_wdata;
      end
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic string test_name(input int t);
      string names [6] = '{"arith", "load_store", "branches", "call_return",
                           "dependent", "halt"};
      return names[t];
   endfunction

   // One LFSR step per bit of the new input word
   task automatic drive_in_word();
      logic [15:0] w;
      w = '0;
      for (int i = 0; i < 16; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         w      = {w[14:0], lfsr_q[0]};
      end
      in_data <= w;
   endtask

   task automatic finish_test(input int t);
      if (t == 1) begin
         for (int i = 0; i < 2; i++) begin
            assert (dmem[chk_addr[i]] == chk_val[i]) else begin
               $display("[ERROR] %s: expected %h, actual %h at address %0d", test_name(t),
                        chk_val[i], dmem[chk_addr[i]], chk_addr[i]);
               errors++;
               test_err[t]++;
            end
         end
      end
      if (test_err[t] == 0) passed++;
      else failed++;
      $display("Test %s finished with %0d errors", test_name(t), test_err[t]);
   endtask

   // New input word after every output pulse
   always @(posedge clk) begin
      if (rst_n && out_valid) begin
         drive_in_word();
      end
   end

   always @(posedge clk) begin
      if (rst_n && out_valid) begin
         if (out_idx >= exp_cnt) begin
            $display("Output %h appeared after the expected list was used up", out_data);
            errors++;
            test_err[5]++;
         end else begin
            cur_t = exp_test[out_idx];
            expv  = exp_in[out_idx] ? in_data : exp_val[out_idx];
            assert (out_data == expv) else begin
               $display("[ERROR] %s: expected %h, actual %h", test_name(cur_t), expv, out_data);
               errors++;
               test_err[cur_t]++;
            end
            if (out_idx + 1 == exp_cnt || exp_test[out_idx + 1] != cur_t) begin
               finish_test(cur_t);
            end
            out_idx++;
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted) else begin
      $display("Halted dropped after it was set");
      errors++;
      test_err[5]++;
   end

   assert property (@(posedge clk) disable iff (!rst_n) halted |-> !out_valid) else begin
      $display("Output pulse seen while halted");
      errors++;
      test_err[5]++;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, halted never settled", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial begin
      clk     = 1'b0;
      rst_n   = 1'b0;
      in_data = '0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = alu_inst(4'd15, 3'd0, 3'd0);
         dmem[i] = {~i[7:0], i[7:0]};
      end
      for (int i = 0; i < 6; i++) begin
         test_err[i] = 0;
      end
      load_program();
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      wait (halted === 1'b1);
      repeat (10) @(posedge clk);
      assert (out_idx == exp_cnt) else begin
         $display("Output count %0d does not match the %0d expected", out_idx, exp_cnt);
         errors++;
         test_err[5]++;
      end
      finish_test(5);
      $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: list.f
hw/simple_pkg.sv
hw/ctrl_if.sv
hw/controller.sv
hw/hazard_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_unit.sv
hw/ex_stage.sv
hw/simple_core.sv
tests/tb_simple_core.sv
+incdir+tests
